// File: cpuCore.f
+incdir+source
source/isaPkg.sv
source/pipePkg.sv
source/instructionDecoder.sv
source/registerFile.sv
source/operandForward.sv
source/pipelineRegister.sv
source/fetchDecode.sv
source/executeStage.sv
source/memoryStage.sv
source/cpuCore.sv
verif/clockGen.sv
verif/cpuCoreTb.sv

// File: verif/cpuCoreTb.sv
`timescale 1ns/1ps
`include "cpuCore_macros.svh"

module cpuCoreTb;
    import isaPkg::*;

    typedef struct packed {
        wordT   pc;
        logic   regWrite;
        regIdxT dest;
        wordT   data;
    } retireT;

    logic clk;
    logic reset;
    wordT instr;
    wordT pc;
    logic retireValid;
    wordT retirePc;
    logic retireRegWrite;
    regIdxT retireReg;
    wordT retireData;

    wordT progMem [256];
    int progLen;
    retireT expected [$];
    logic checking;
    wordT rngState;
    int cycleBudget = 100;
    int cycleCount = 0;

    clockGen #(.periodNs(40.0)) clock (.clk(clk));

    cpuCore cpuCore_i (
        .clk(clk), .reset(reset), .instr(instr), .pc(pc),
        .retireValid(retireValid), .retirePc(retirePc), .retireRegWrite(retireRegWrite),
        .retireReg(retireReg), .retireData(retireData)
    );

    task automatic reportFailure(input string line);
        $display("%s", line);
        $display("Finished with errors");
        $fatal(1);
    endtask

    task automatic checkEqual(input string what, input wordT actual, input wordT exp);
        if (actual !== exp) begin
            reportFailure($sformatf("Mismatch at %0t ns: %s is %h, expected %h",
                                    $time, what, actual, exp));
        end
    endtask

    function automatic wordT nextRandom();
        rngState ^= rngState << 13;
        rngState ^= rngState >> 17;
        rngState ^= rngState << 5;
        return rngState;
    endfunction

    task automatic emitI(input opcodeT op, input regIdxT rs, input regIdxT rt,
                         input logic [15:0] imm);
        progMem[8'(progLen)] = {op, rs, rt, imm};
        progLen++;
    endtask

    task automatic emitR(input functT fn, input regIdxT rs, input regIdxT rt, input regIdxT rd);
        progMem[8'(progLen)] = {opSpecial, rs, rt, rd, 5'd0, fn};
        progLen++;
    endtask

    task automatic loadImm(input regIdxT rd, input wordT value);
        emitI(opLui, 0, rd, value[31:16]);
        emitI(opOri, rd, rd, value[15:0]);
    endtask

    // Architectural model with one delay slot after every branch and jump
    task automatic buildExpected();
        wordT regs [32];
        wordT mem [256];
        wordT pcNow;
        wordT pcNext;
        wordT pcAfter;
        wordT w;
        wordT a;
        wordT b;
        wordT imm;
        wordT addr;
        retireT r;
        regs = '{default: '0};
        mem = '{default: '0};
        pcNow = `RESET_PC;
        pcNext = pcNow + 4;
        expected.delete();
        while (pcNow < 4 * progLen) begin
            w = progMem[pcNow[9:2]];
            a = regs[w[25:21]];
            b = regs[w[20:16]];
            imm = {{16{w[15]}}, w[15:0]};
            addr = a + imm;
            pcAfter = pcNext + 4;
            r = '{pc: pcNow, regWrite: 1'b1, dest: w[20:16], data: addr};
            case (w[31:26])
                opSpecial: begin
                    r.dest = w[15:11];
                    case (w[5:0])
                        fnAddu: r.data = a + b;
                        fnSubu: r.data = a - b;
                        fnAnd: r.data = a & b;
                        fnOr: r.data = a | b;
                        fnSlt: r.data = {31'b0, $signed(a) < $signed(b)};
                        default: r.regWrite = 1'b0;
                    endcase
                end
                opAddiu: ;
                opOri: r.data = a | {16'b0, w[15:0]};
                opLui: r.data = {w[15:0], 16'b0};
                opLw: r.data = mem[addr[9:2]];
                opSw: begin
                    r.regWrite = 1'b0;
                    mem[addr[9:2]] = b;
                end
                opBeq, opBne: begin
                    r.regWrite = 1'b0;
                    if ((a == b) == (w[31:26] == opBeq)) begin
                        pcAfter = pcNow + 4 + (imm << 2);
                    end
                end
                opJ: begin
                    r.regWrite = 1'b0;
                    pcAfter = {pcNow[31:28], w[25:0], 2'b00};
                end
                default: r.regWrite = 1'b0;
            endcase
            if (r.regWrite && r.dest != '0) begin
                regs[r.dest] = r.data;
            end
            expected.push_back(r);
            pcNow = pcNext;
            pcNext = pcAfter;
        end
    endtask

    task automatic applyReset();
        @(posedge clk);
        #2;
        reset = 1'b1;
        checking = 1'b0;
        repeat (8) @(posedge clk);
        #1;
        checkEqual("pc in reset", pc, `RESET_PC);
        checkEqual("retireValid in reset", 32'(retireValid), 32'd0);
        checkEqual("retireRegWrite in reset", 32'(retireRegWrite), 32'd0);
        #1;
        reset = 1'b0;
        checking = 1'b1;
    endtask

    task automatic startProgram();
        progMem = '{default: '0};
        progLen = 0;
    endtask

    task automatic runProgram();
        cycleBudget += 10 * progLen;
        buildExpected();
        applyReset();
        while (expected.size() != 0) begin
            @(posedge clk);
        end
        // Only no-ops may retire past the end
        repeat (6) @(posedge clk);
        checking = 1'b0;
    endtask

    // Instruction port answers the current pc
    always @(posedge clk) begin
        #2;
        instr <= $isunknown(pc) ? '0 : progMem[pc[9:2]];
    end

    always @(negedge clk) begin
        if (checking && retireValid !== 1'b0) begin
            if (expected.size() == 0) begin
                if (retireRegWrite !== 1'b0) begin
                    reportFailure("A register write retired after the end of the program");
                end
            end else begin
                checkEqual("retirePc", retirePc, expected[0].pc);
                checkEqual("retireRegWrite", 32'(retireRegWrite), 32'(expected[0].regWrite));
                if (expected[0].regWrite) begin
                    checkEqual("retireReg", 32'(retireReg), 32'(expected[0].dest));
                    checkEqual("retireData", retireData, expected[0].data);
                end
                void'(expected.pop_front());
            end
        end
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > cycleBudget) begin
            reportFailure("Timeout, the core did not retire the whole program in time");
        end
    end

    task automatic aluChainTest();
        functT fns [5];
        wordT rnd;
        fns = '{fnAddu, fnSubu, fnAnd, fnOr, fnSlt};
        startProgram();
        loadImm(1, nextRandom());
        loadImm(2, nextRandom());
        rnd = nextRandom();
        emitI(opAddiu, 1, 3, rnd[15:0]);
        emitR(fnAddu, 3, 2, 4);
        emitR(fnSubu, 4, 1, 5);
        emitR(fnAnd, 5, 3, 6);
        emitR(fnOr, 6, 2, 7);
        emitR(fnSlt, 7, 5, 8);
        emitR(fnSlt, 1, 2, 9);
        emitR(fnAddu, 8, 9, 10);
        emitI(opOri, 10, 11, rnd[31:16]);
        emitR(fnSubu, 11, 4, 12);
        // Random mix hits every forwarding distance
        repeat (16) begin
            rnd = nextRandom();
            emitR(fns[3'(rnd % 5)], regIdxT'(rnd[11:8] % 13), regIdxT'(rnd[15:12] % 13),
                  regIdxT'(rnd[19:16] % 12 + 1));
        end
        runProgram();
    endtask

    task automatic loadUseTest();
        startProgram();
        loadImm(1, nextRandom());
        loadImm(2, nextRandom());
        emitI(opSw, 0, 1, 16'h0040);
        emitI(opSw, 0, 2, 16'h0044);
        emitI(opLw, 0, 3, 16'h0040);
        emitR(fnAddu, 3, 2, 4);
        emitI(opLw, 0, 5, 16'h0044);
        emitR(fnSubu, 4, 5, 6);
        emitI(opLw, 0, 7, 16'h0040);
        emitI(opAddiu, 0, 8, 16'h0044);
        emitR(fnOr, 7, 5, 9);
        emitI(opLw, 8, 10, 16'h0000);
        emitI(opSw, 0, 10, 16'h0048);
        emitI(opLw, 0, 11, 16'h0048);
        runProgram();
    endtask

    task automatic storeLoadTest();
        startProgram();
        loadImm(1, nextRandom());
        loadImm(2, nextRandom());
        emitI(opSw, 0, 1, 16'h0100);
        emitI(opAddiu, 1, 3, 16'h0007);
        emitI(opSw, 0, 3, 16'h0104);
        emitI(opAddiu, 0, 4, 16'h0200);
        emitI(opSw, 4, 2, 16'hfffc);
        emitR(fnSubu, 2, 1, 5);
        emitI(opSw, 4, 5, 16'h0010);
        emitI(opLw, 4, 6, 16'h0010);
        emitI(opLw, 0, 7, 16'h0104);
        emitI(opLw, 4, 8, 16'hfffc);
        emitI(opLw, 0, 9, 16'h0100);
        emitI(opLw, 0, 10, 16'h0108);
        emitR(fnAddu, 6, 7, 11);
        runProgram();
    endtask

    task automatic branchTest();
        startProgram();
        emitI(opAddiu, 0, 1, 16'd5);
        emitI(opAddiu, 0, 2, 16'd5);
        emitI(opBeq, 1, 2, 16'd2);
        emitI(opAddiu, 0, 3, 16'd1);
        emitI(opAddiu, 0, 4, 16'd2);
        emitI(opBne, 1, 2, 16'd3);
        emitI(opAddiu, 0, 5, 16'd3);
        emitI(opAddiu, 2, 2, 16'd1);
        emitI(opBne, 1, 2, 16'd2);
        emitR(fnAddu, 1, 2, 6);
        emitI(opAddiu, 0, 7, 16'd9);
        emitI(opBeq, 1, 2, 16'd5);
        emitR(fnOr, 1, 2, 8);
        // Jump field lands on word 16
        emitI(opJ, 0, 0, 16'd16);
        emitR(fnSubu, 2, 1, 9);
        emitI(opAddiu, 0, 10, 16'd1);
        emitI(opSw, 0, 1, 16'h0020);
        emitI(opLw, 0, 11, 16'h0020);
        emitI(opBeq, 11, 1, 16'd2);
        emitI(opAddiu, 0, 12, 16'd4);
        emitI(opAddiu, 0, 13, 16'd5);
        emitI(opAddiu, 0, 14, 16'd6);
        runProgram();
    endtask

    task automatic zeroRegAndResetTest();
        startProgram();
        emitI(opAddiu, 0, 0, 16'h0055);
        emitR(fnAddu, 0, 0, 1);
        emitI(opAddiu, 0, 2, 16'h1234);
        emitR(fnOr, 0, 2, 3);
        emitI(opSw, 0, 3, 16'h0010);
        emitI(opLw, 0, 4, 16'h0010);
        emitR(fnAddu, 4, 0, 5);
        runProgram();
        // Second reset must leave registers and memory at zero
        startProgram();
        emitI(opLw, 0, 6, 16'h0010);
        emitR(fnAddu, 2, 6, 7);
        emitR(fnOr, 3, 0, 8);
        emitR(fnAddu, 5, 4, 9);
        runProgram();
    endtask

    initial begin
        reset = 1'b1;
        instr = '0;
        checking = 1'b0;
        rngState = 32'h7afecc08;
        aluChainTest();
        loadUseTest();
        storeLoadTest();
        branchTest();
        zeroRegAndResetTest();
        $display("Finished with no errors");
        $finish;
    end

endmodule

// File: verif/clockGen.sv
`timescale 1ns/1ps

module clockGen #(
    parameter real periodNs = 40.0
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #(periodNs / 2.0) clk = ~clk;
        end
    end

endmodule

// File: source/cpuCore.sv
`timescale 1ns/1ps

module cpuCore (
    input  logic           clk,
    input  logic           reset,
    input  isaPkg::wordT   instr,
    output isaPkg::wordT   pc,
    output logic           retireValid,
    output isaPkg::wordT   retirePc,
    output logic           retireRegWrite,
    output isaPkg::regIdxT retireReg,
    output isaPkg::wordT   retireData
);
    import isaPkg::*;
    import pipePkg::*;

    execPayloadT execPayloadNext;
    execPayloadT execPayload;
    memPayloadT memPayloadNext;
    memPayloadT memPayload;
    wbPayloadT wbPayloadNext;
    wbPayloadT wbPayload;
    logic bubble;
    logic execFwdValid;
    logic execFwdIsLoad;
    regIdxT execFwdReg;
    wordT execFwdValue;
    logic memFwdValid;
    regIdxT memFwdReg;
    wordT memFwdValue;
    logic wbFwdValid;

    fetchDecode frontEnd (
        .clk(clk), .reset(reset), .instr(instr), .pc(pc),
        .execFwdValid(execFwdValid), .execFwdIsLoad(execFwdIsLoad),
        .execFwdReg(execFwdReg), .execFwdValue(execFwdValue),
        .memFwdValid(memFwdValid), .memFwdReg(memFwdReg), .memFwdValue(memFwdValue),
        .wbFwdValid(wbFwdValid), .wbFwdReg(wbPayload.dest), .wbFwdValue(wbPayload.result),
        .execPayload(execPayloadNext), .bubble(bubble)
    );

    pipelineRegister #(.payloadT(execPayloadT)) execReg (
        .clk(clk), .reset(reset), .hold(1'b0), .bubble(bubble),
        .in(execPayloadNext), .out(execPayload)
    );

    executeStage execute (
        .execPayload(execPayload),
        .memFwdValid(memFwdValid), .memFwdReg(memFwdReg), .memFwdValue(memFwdValue),
        .wbFwdValid(wbFwdValid), .wbFwdReg(wbPayload.dest), .wbFwdValue(wbPayload.result),
        .execFwdValid(execFwdValid), .execFwdIsLoad(execFwdIsLoad),
        .execFwdReg(execFwdReg), .execFwdValue(execFwdValue),
        .memPayload(memPayloadNext)
    );

    pipelineRegister #(.payloadT(memPayloadT)) memReg (
        .clk(clk), .reset(reset), .hold(1'b0), .bubble(1'b0),
        .in(memPayloadNext), .out(memPayload)
    );

    memoryStage memory (
        .clk(clk), .reset(reset), .memPayload(memPayload),
        .memFwdValid(memFwdValid), .memFwdReg(memFwdReg), .memFwdValue(memFwdValue),
        .wbPayload(wbPayloadNext)
    );

    pipelineRegister #(.payloadT(wbPayloadT)) wbReg (
        .clk(clk), .reset(reset), .hold(1'b0), .bubble(1'b0),
        .in(wbPayloadNext), .out(wbPayload)
    );

    // Writeback register is the retire point
    assign wbFwdValid = wbPayload.valid && wbPayload.regWrite;
    assign retireValid = wbPayload.valid;
    assign retirePc = wbPayload.pc;
    assign retireRegWrite = wbFwdValid;
    assign retireReg = wbPayload.dest;
    assign retireData = wbPayload.result;

endmodule

// File: source/memoryStage.sv
`timescale 1ns/1ps
`include "cpuCore_macros.svh"

module memoryStage (
    input  logic                clk,
    input  logic                reset,
    input  pipePkg::memPayloadT memPayload,
    output logic                memFwdValid,
    output isaPkg::regIdxT      memFwdReg,
    output isaPkg::wordT        memFwdValue,
    output pipePkg::wbPayloadT  wbPayload
);
    import isaPkg::*;

    localparam int addrW = $clog2(`DMEM_WORDS);

    wordT dmem [`DMEM_WORDS];
    logic [addrW-1:0] wordAddr;
    wordT result;

    // Word index, upper address bits wrap
    assign wordAddr = memPayload.aluResult[addrW+1:2];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `DMEM_WORDS; i++) begin
                dmem[i] <= '0;
            end
        end else if (memPayload.valid && memPayload.ctrl.store) begin
            dmem[wordAddr] <= memPayload.storeData;
        end
    end

    assign result = memPayload.ctrl.load ? dmem[wordAddr] : memPayload.aluResult;

    assign memFwdValid = memPayload.valid && memPayload.ctrl.regWrite;
    assign memFwdReg = memPayload.ctrl.dest;
    assign memFwdValue = result;

    always_comb begin
        wbPayload.valid = memPayload.valid;
        wbPayload.pc = memPayload.pc;
        wbPayload.dest = memPayload.ctrl.dest;
        wbPayload.regWrite = memPayload.ctrl.regWrite;
        wbPayload.result = result;
    end

endmodule

// File: source/executeStage.sv
`timescale 1ns/1ps

module executeStage (
    input  pipePkg::execPayloadT execPayload,
    input  logic                 memFwdValid,
    input  isaPkg::regIdxT       memFwdReg,
    input  isaPkg::wordT         memFwdValue,
    input  logic                 wbFwdValid,
    input  isaPkg::regIdxT       wbFwdReg,
    input  isaPkg::wordT         wbFwdValue,
    output logic                 execFwdValid,
    output logic                 execFwdIsLoad,
    output isaPkg::regIdxT       execFwdReg,
    output isaPkg::wordT         execFwdValue,
    output pipePkg::memPayloadT  memPayload
);
    import isaPkg::*;

    regIdxT src1;
    regIdxT src2;
    wordT opA;
    wordT opB;
    wordT aluB;
    wordT result;

    assign src1 = execPayload.ctrl.src1Req ? execPayload.ctrl.src1 : '0;
    assign src2 = execPayload.ctrl.src2Req ? execPayload.ctrl.src2 : '0;

    operandForward fwdA (
        .srcReg(src1), .original(execPayload.opA),
        .memValid(memFwdValid), .memReg(memFwdReg), .memValue(memFwdValue),
        .wbValid(wbFwdValid), .wbReg(wbFwdReg), .wbValue(wbFwdValue),
        .value(opA)
    );

    operandForward fwdB (
        .srcReg(src2), .original(execPayload.opB),
        .memValid(memFwdValid), .memReg(memFwdReg), .memValue(memFwdValue),
        .wbValid(wbFwdValid), .wbReg(wbFwdReg), .wbValue(wbFwdValue),
        .value(opB)
    );

    assign aluB = execPayload.ctrl.immAsB ? execPayload.ctrl.imm : opB;

    always_comb begin
        case (execPayload.ctrl.aluOp)
            aluSub: result = opA - aluB;
            aluAnd: result = opA & aluB;
            aluOr: result = opA | aluB;
            aluSlt: result = wordT'($signed(opA) < $signed(aluB));
            aluLui: result = {aluB[15:0], 16'b0};
            default: result = opA + aluB;
        endcase
    end

    // A load in flight only signals the hazard
    assign execFwdValid = execPayload.valid && execPayload.ctrl.regWrite
                          && !execPayload.ctrl.load;
    assign execFwdIsLoad = execPayload.valid && execPayload.ctrl.load;
    assign execFwdReg = execPayload.ctrl.dest;
    assign execFwdValue = result;

    always_comb begin
        memPayload.valid = execPayload.valid;
        memPayload.ctrl = execPayload.ctrl;
        memPayload.pc = execPayload.pc;
        memPayload.aluResult = result;
        memPayload.storeData = opB;
    end

endmodule

// File: source/fetchDecode.sv
`timescale 1ns/1ps
`include "cpuCore_macros.svh"

module fetchDecode (
    input  logic                 clk,
    input  logic                 reset,
    input  isaPkg::wordT         instr,
    output isaPkg::wordT         pc,
    input  logic                 execFwdValid,
    input  logic                 execFwdIsLoad,
    input  isaPkg::regIdxT       execFwdReg,
    input  isaPkg::wordT         execFwdValue,
    input  logic                 memFwdValid,
    input  isaPkg::regIdxT       memFwdReg,
    input  isaPkg::wordT         memFwdValue,
    input  logic                 wbFwdValid,
    input  isaPkg::regIdxT       wbFwdReg,
    input  isaPkg::wordT         wbFwdValue,
    output pipePkg::execPayloadT execPayload,
    output logic                 bubble
);
    import isaPkg::*;
    import pipePkg::*;

    wordT fdInstr;
    wordT fdPc;
    logic fdValid;
    ctrlT ctrl;
    regIdxT src1;
    regIdxT src2;
    wordT regData1;
    wordT regData2;
    wordT opA;
    wordT opB;
    logic stall;
    logic taken;
    wordT target;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= `RESET_PC;
            fdValid <= 1'b0;
        end else if (!stall) begin
            pc <= taken ? target : pc + 32'd4;
            fdInstr <= instr;
            fdPc <= pc;
            fdValid <= 1'b1;
        end
    end

    instructionDecoder decoder (.instr(fdInstr), .ctrl(ctrl));

    // Unused source fields must not match anything
    assign src1 = ctrl.src1Req ? ctrl.src1 : '0;
    assign src2 = ctrl.src2Req ? ctrl.src2 : '0;

    registerFile regFile (
        .clk(clk), .reset(reset),
        .readReg1(src1), .readReg2(src2),
        .readData1(regData1), .readData2(regData2),
        .writeEnable(wbFwdValid), .writeReg(wbFwdReg), .writeData(wbFwdValue)
    );

    operandForward fwdA (
        .srcReg(src1), .original(regData1),
        .execValid(execFwdValid), .execReg(execFwdReg), .execValue(execFwdValue),
        .memValid(memFwdValid), .memReg(memFwdReg), .memValue(memFwdValue),
        .wbValid(wbFwdValid), .wbReg(wbFwdReg), .wbValue(wbFwdValue),
        .value(opA)
    );

    operandForward fwdB (
        .srcReg(src2), .original(regData2),
        .execValid(execFwdValid), .execReg(execFwdReg), .execValue(execFwdValue),
        .memValid(memFwdValid), .memReg(memFwdReg), .memValue(memFwdValue),
        .wbValid(wbFwdValid), .wbReg(wbFwdReg), .wbValue(wbFwdValue),
        .value(opB)
    );

    // Load result not ready until the memory stage
    assign stall = fdValid && execFwdIsLoad && execFwdReg != '0
                   && (execFwdReg == src1 || execFwdReg == src2);
    assign bubble = stall;

    assign taken = fdValid && !stall
                   && (ctrl.jump || (ctrl.branchEq && opA == opB)
                       || (ctrl.branchNe && opA != opB));
    assign target = ctrl.jump ? {fdPc[31:28], ctrl.imm[25:0], 2'b00}
                              : fdPc + 32'd4 + (ctrl.imm << 2);

    always_comb begin
        execPayload.valid = fdValid;
        execPayload.ctrl = ctrl;
        execPayload.pc = fdPc;
        execPayload.opA = opA;
        execPayload.opB = opB;
    end

endmodule

// File: source/pipelineRegister.sv
`timescale 1ns/1ps

module pipelineRegister #(
    parameter type payloadT = logic
) (
    input  logic    clk,
    input  logic    reset,
    input  logic    hold,
    input  logic    bubble,
    input  payloadT in,
    output payloadT out
);

    // An all-zero payload has its valid bit clear
    always_ff @(posedge clk) begin
        if (reset || bubble) begin
            out <= '0;
        end else if (!hold) begin
            out <= in;
        end
    end

endmodule

// File: source/operandForward.sv
`timescale 1ns/1ps

module operandForward (
    input  isaPkg::regIdxT srcReg,
    input  isaPkg::wordT   original,
    input  logic           execValid = 1'b0,
    input  isaPkg::regIdxT execReg = '0,
    input  isaPkg::wordT   execValue = '0,
    input  logic           memValid,
    input  isaPkg::regIdxT memReg,
    input  isaPkg::wordT   memValue,
    input  logic           wbValid,
    input  isaPkg::regIdxT wbReg,
    input  isaPkg::wordT   wbValue,
    output isaPkg::wordT   value
);

    // Nearest stage first, register 0 is never forwarded
    always_comb begin
        value = original;
        if (srcReg != '0) begin
            if (execValid && execReg == srcReg) begin
                value = execValue;
            end else if (memValid && memReg == srcReg) begin
                value = memValue;
            end else if (wbValid && wbReg == srcReg) begin
                value = wbValue;
            end
        end
    end

endmodule

// File: source/registerFile.sv
`timescale 1ns/1ps
`include "cpuCore_macros.svh"

module registerFile (
    input  logic           clk,
    input  logic           reset,
    input  isaPkg::regIdxT readReg1,
    input  isaPkg::regIdxT readReg2,
    output isaPkg::wordT   readData1,
    output isaPkg::wordT   readData2,
    input  logic           writeEnable,
    input  isaPkg::regIdxT writeReg,
    input  isaPkg::wordT   writeData
);
    import isaPkg::*;

    wordT regs [`REG_COUNT];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEnable && writeReg != '0) begin
            regs[writeReg] <= writeData;
        end
    end

    // Old value on a same-cycle write, the bypass is done by forwarding
    assign readData1 = regs[readReg1];
    assign readData2 = regs[readReg2];

endmodule

// File: source/instructionDecoder.sv
`timescale 1ns/1ps

module instructionDecoder (
    input  isaPkg::wordT  instr,
    output pipePkg::ctrlT ctrl
);
    import isaPkg::*;

    wordT signImm;
    wordT zeroImm;

    assign signImm = {{16{instr[15]}}, instr[15:0]};
    assign zeroImm = {16'b0, instr[15:0]};

    always_comb begin
        // Anything not matched below stays a no-op
        ctrl = '0;
        ctrl.aluOp = aluAdd;
        ctrl.imm = signImm;
        ctrl.src1 = instr[25:21];
        ctrl.src2 = instr[20:16];
        case (instr[31:26])
            opSpecial: begin
                ctrl.dest = instr[15:11];
                ctrl.regWrite = 1'b1;
                ctrl.src1Req = 1'b1;
                ctrl.src2Req = 1'b1;
                case (instr[5:0])
                    fnAddu: ctrl.aluOp = aluAdd;
                    fnSubu: ctrl.aluOp = aluSub;
                    fnAnd: ctrl.aluOp = aluAnd;
                    fnOr: ctrl.aluOp = aluOr;
                    fnSlt: ctrl.aluOp = aluSlt;
                    default: begin
                        ctrl.dest = '0;
                        ctrl.regWrite = 1'b0;
                        ctrl.src1Req = 1'b0;
                        ctrl.src2Req = 1'b0;
                    end
                endcase
            end
            opAddiu, opOri, opLui, opLw: begin
                ctrl.dest = instr[20:16];
                ctrl.regWrite = 1'b1;
                ctrl.immAsB = 1'b1;
                ctrl.src1Req = (instr[31:26] != opLui);
                ctrl.load = (instr[31:26] == opLw);
                if (instr[31:26] == opOri) begin
                    ctrl.aluOp = aluOr;
                    ctrl.imm = zeroImm;
                end else if (instr[31:26] == opLui) begin
                    ctrl.aluOp = aluLui;
                    ctrl.imm = zeroImm;
                end
            end
            opSw: begin
                ctrl.store = 1'b1;
                ctrl.immAsB = 1'b1;
                ctrl.src1Req = 1'b1;
                ctrl.src2Req = 1'b1;
            end
            opBeq, opBne: begin
                ctrl.branchEq = (instr[31:26] == opBeq);
                ctrl.branchNe = (instr[31:26] == opBne);
                ctrl.src1Req = 1'b1;
                ctrl.src2Req = 1'b1;
            end
            opJ: begin
                ctrl.jump = 1'b1;
                ctrl.imm = {6'b0, instr[25:0]};
            end
            default: ;
        endcase
    end

endmodule

// File: source/pipePkg.sv
package pipePkg;

    // Decoded control, travels with the instruction
    typedef struct packed {
        isaPkg::aluOpT  aluOp;
        logic           immAsB;
        isaPkg::wordT   imm;
        isaPkg::regIdxT dest;
        logic           regWrite;
        logic           load;
        logic           store;
        logic           branchEq;
        logic           branchNe;
        logic           jump;
        isaPkg::regIdxT src1;
        logic           src1Req;
        isaPkg::regIdxT src2;
        logic           src2Req;
    } ctrlT;

    typedef struct packed {
        logic         valid;
        ctrlT         ctrl;
        isaPkg::wordT pc;
        isaPkg::wordT opA;
        isaPkg::wordT opB;
    } execPayloadT;

    typedef struct packed {
        logic         valid;
        ctrlT         ctrl;
        isaPkg::wordT pc;
        isaPkg::wordT aluResult;
        isaPkg::wordT storeData;
    } memPayloadT;

    typedef struct packed {
        logic           valid;
        isaPkg::wordT   pc;
        isaPkg::regIdxT dest;
        logic           regWrite;
        isaPkg::wordT   result;
    } wbPayloadT;

endpackage

// File: source/isaPkg.sv
`include "cpuCore_macros.svh"

package isaPkg;

    typedef logic [`XLEN-1:0] wordT;
    typedef logic [`REG_ADDR_W-1:0] regIdxT;

    // Primary opcodes of the supported subset
    typedef enum logic [5:0] {
        opSpecial = 6'h00,
        opJ       = 6'h02,
        opBeq     = 6'h04,
        opBne     = 6'h05,
        opAddiu   = 6'h09,
        opOri     = 6'h0d,
        opLui     = 6'h0f,
        opLw      = 6'h23,
        opSw      = 6'h2b
    } opcodeT;

    // R-type function field
    typedef enum logic [5:0] {
        fnAddu = 6'h21,
        fnSubu = 6'h23,
        fnAnd  = 6'h24,
        fnOr   = 6'h25,
        fnSlt  = 6'h2a
    } functT;

    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluSlt,
        aluLui
    } aluOpT;

endpackage

// File: source/cpuCore_macros.svh
`ifndef CPU_CORE_MACROS_SVH
`define CPU_CORE_MACROS_SVH

// Data path and address width
`define XLEN 32

// Register file geometry
`define REG_ADDR_W 5
`define REG_COUNT 32

// Data memory depth in words
`define DMEM_WORDS 256

// First fetch address after reset
`define RESET_PC 32'h0000_0000

`endif
